/* rtl/arb_pkg.sv */
// ----------------------------------------------------------
// Shared widths, vector typedefs and the pop beat struct
// for the round-robin arbiter subsystem
// ----------------------------------------------------------

package arb_pkg;

  // ----------------------------------------------------------
  // Sizing
  // ----------------------------------------------------------

  // Number of requesters on the push side
  localparam int num_req = 4;

  // Payload width of one requester word
  localparam int data_w = 16;

  // Width of a requester index
  localparam int req_id_w = $clog2(num_req);

  // ----------------------------------------------------------
  // Vector types
  // ----------------------------------------------------------

  // One bit per requester (valid, ready, request, grant)
  typedef logic [num_req-1:0] req_vec_t;

  // One payload word
  typedef logic [data_w-1:0] data_t;

  // Requester index, also used as priority pointer and source tag
  typedef logic [req_id_w-1:0] req_id_t;

  // All requester payloads side by side on one bus
  typedef data_t [num_req-1:0] push_data_t;

  // Beat leaving the arbiter
  // Data in the upper bits, source index in the low bits
  typedef struct packed {
    data_t   data;
    req_id_t src;
  } pop_beat_t;

endpackage

/* rtl/arb_rr_ctrl.sv */
// ----------------------------------------------------------
// Round-robin arbiter control with priority pointer register
// and combinational one-hot grant
// ----------------------------------------------------------

`timescale 1ns/1ps

module arb_rr_ctrl (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              enable,
  input  arb_pkg::req_vec_t request,
  output arb_pkg::req_vec_t grant
);

  // ----------------------------------------------------------
  // Priority state
  // ----------------------------------------------------------

  // Index with the highest priority this cycle
  arb_pkg::req_id_t ptr_q;
  arb_pkg::req_id_t ptr_d;

  // Winner of the wrapped search
  arb_pkg::req_id_t win_idx;

  // Any request present
  logic found;

  // ----------------------------------------------------------
  // Wrapped priority search
  // ----------------------------------------------------------

  always_comb begin
    int unsigned cand;
    found   = 1'b0;
    win_idx = ptr_q;
    grant   = '0;
    // Walk upward from the pointer with wrap-around
    for (int k = 0; k < arb_pkg::num_req; k++) begin
      cand = (int'(ptr_q) + k) % arb_pkg::num_req;
      // First requester found keeps the win
      if (!found && request[cand]) begin
        found   = 1'b1;
        win_idx = arb_pkg::req_id_t'(cand);
      end
    end
    // No grant while the consumer side is stalled
    if (enable && found) begin
      grant[win_idx] = 1'b1;
    end
  end

  // Next pointer sits one past the winner
  always_comb begin
    if (win_idx == arb_pkg::req_id_t'(arb_pkg::num_req - 1)) begin
      ptr_d = '0;
    end else begin
      ptr_d = arb_pkg::req_id_t'(win_idx + 1'b1);
    end
  end

  // ----------------------------------------------------------
  // Pointer register
  // ----------------------------------------------------------

  // Moves only on an edge where a grant is taken
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      ptr_q <= '0;
    end else if (enable && found) begin
      ptr_q <= ptr_d;
    end
  end

endmodule

/* rtl/flow_arb_rr.sv */
// ----------------------------------------------------------
// Ready/valid wrapper around the round-robin arbiter control
// ----------------------------------------------------------

`timescale 1ns/1ps

module flow_arb_rr (
  input  logic              clk,
  input  logic              rst_n,
  input  arb_pkg::req_vec_t push_valid,
  output arb_pkg::req_vec_t push_ready,
  input  logic              pop_ready,
  output logic              pop_valid,
  output arb_pkg::req_vec_t grant
);

  // ----------------------------------------------------------
  // Arbiter control
  // ----------------------------------------------------------

  // Valids act as requests
  // Pop ready gates the grant and the pointer update
  arb_rr_ctrl u_ctrl (
    .clk     (clk),
    .rst_n   (rst_n),
    .enable  (pop_ready),
    .request (push_valid),
    .grant   (grant)
  );

  // ----------------------------------------------------------
  // Push ready
  // ----------------------------------------------------------

  // Ready whenever no other requester holds the grant
  // Own valid never feeds its own ready
  // Ready and valid together reduce to the grant bit itself
  for (genvar i = 0; i < arb_pkg::num_req; i++) begin : g_ready
    // Grant with bit i masked out
    arb_pkg::req_vec_t other_grant;

    assign other_grant   = grant & ~(arb_pkg::req_vec_t'(1) << i);
    assign push_ready[i] = ~|other_grant;
  end

  // ----------------------------------------------------------
  // Pop valid
  // ----------------------------------------------------------

  // Something to pop as soon as any requester is valid
  assign pop_valid = |push_valid;

endmodule

/* rtl/grant_mux.sv */
// ----------------------------------------------------------
// Payload mux and source encoder under a one-hot grant
// ----------------------------------------------------------

`timescale 1ns/1ps

module grant_mux (
  input  arb_pkg::req_vec_t   grant,
  input  arb_pkg::push_data_t push_data,
  output arb_pkg::pop_beat_t  beat_in
);

  // ----------------------------------------------------------
  // AND-OR select
  // ----------------------------------------------------------

  // Granted word only
  arb_pkg::data_t sel_data;

  // Index of the granted requester
  arb_pkg::req_id_t sel_src;

  always_comb begin
    sel_data = '0;
    sel_src  = '0;
    for (int i = 0; i < arb_pkg::num_req; i++) begin
      // Each word masked by its own grant bit
      sel_data = sel_data | (push_data[i] & {arb_pkg::data_w{grant[i]}});
      // One-hot to binary by OR of the set positions
      if (grant[i]) begin
        sel_src = sel_src | arb_pkg::req_id_t'(i);
      end
    end
  end

  // ----------------------------------------------------------
  // Beat assembly
  // ----------------------------------------------------------

  // Meaningful only while grant is nonzero
  always_comb begin
    beat_in      = '0;
    beat_in.data = sel_data;
    beat_in.src  = sel_src;
  end

endmodule

/* rtl/pop_stage.sv */
// ----------------------------------------------------------
// Single ready/valid register stage for the outgoing beat
// ----------------------------------------------------------

`timescale 1ns/1ps

module pop_stage (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               in_valid,
  input  arb_pkg::pop_beat_t in_beat,
  output logic               in_ready,
  output logic               out_valid,
  output arb_pkg::pop_beat_t out_beat,
  input  logic               out_ready
);

  // ----------------------------------------------------------
  // Stage state
  // ----------------------------------------------------------

  // Stage holds a beat
  logic valid_q;

  // Held beat
  arb_pkg::pop_beat_t beat_q;

  // Accept a new beat this cycle
  logic load;

  // ----------------------------------------------------------
  // Handshake
  // ----------------------------------------------------------

  // Free when empty or draining this cycle
  // Keeps one beat per cycle while out_ready stays high
  assign in_ready = ~valid_q | out_ready;

  assign load = in_ready & in_valid;

  // Valid bit follows the input whenever the stage can move
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      valid_q <= 1'b0;
    end else if (in_ready) begin
      valid_q <= in_valid;
    end
  end

  // Beat loads only on an actual transfer
  // held stable under a stall
  always_ff @(posedge clk) begin
    if (load) begin
      beat_q <= in_beat;
    end
  end

  // ----------------------------------------------------------
  // Outputs
  // ----------------------------------------------------------

  assign out_valid = valid_q;
  assign out_beat  = beat_q;

endmodule

/* rtl/arb_top.sv */
// ----------------------------------------------------------
// Arbiter subsystem top with flow wrapper, payload mux and
// output register stage
// ----------------------------------------------------------

`timescale 1ns/1ps

module arb_top (
  input  logic                clk,
  input  logic                rst_n,
  input  arb_pkg::req_vec_t   push_valid,
  output arb_pkg::req_vec_t   push_ready,
  input  arb_pkg::push_data_t push_data,
  output logic                out_valid,
  output arb_pkg::pop_beat_t  out_beat,
  input  logic                out_ready
);

  // ----------------------------------------------------------
  // Internal wires
  // ----------------------------------------------------------

  // Any requester valid
  logic pop_valid;

  // Output stage can take a beat
  logic stage_ready;

  // One-hot winner of this cycle
  arb_pkg::req_vec_t grant;

  // Selected beat toward the output stage
  arb_pkg::pop_beat_t beat_in;

  // ----------------------------------------------------------
  // Arbitration and push handshake
  // ----------------------------------------------------------

  flow_arb_rr u_flow (
    .clk        (clk),
    .rst_n      (rst_n),
    .push_valid (push_valid),
    .push_ready (push_ready),
    .pop_ready  (stage_ready),
    .pop_valid  (pop_valid),
    .grant      (grant)
  );

  // Payload select and source tag
  grant_mux u_mux (
    .grant     (grant),
    .push_data (push_data),
    .beat_in   (beat_in)
  );

  // ----------------------------------------------------------
  // Output register stage
  // ----------------------------------------------------------

  pop_stage u_stage (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (pop_valid),
    .in_beat   (beat_in),
    .in_ready  (stage_ready),
    .out_valid (out_valid),
    .out_beat  (out_beat),
    .out_ready (out_ready)
  );

endmodule

/* tb/arb_asserts.sv */
// ----------------------------------------------------------
// Concurrent handshake assertions bound to the arbiter top
// ----------------------------------------------------------

`timescale 1ns/1ps

module arb_asserts (
  input logic               clk,
  input logic               rst_n,
  input arb_pkg::req_vec_t  push_valid,
  input arb_pkg::req_vec_t  push_ready,
  input logic               stage_ready,
  input logic               out_valid,
  input logic               out_ready,
  input arb_pkg::pop_beat_t out_beat
);

  // Failed assertion count, read by the testbench at the end
  int fail_cnt = 0;

  // Pushes that really transfer this cycle
  arb_pkg::req_vec_t taken;

  assign taken = push_valid & push_ready & {arb_pkg::num_req{stage_ready}};

  a_one_push: assert property (@(posedge clk) disable iff (!rst_n)
    $onehot0(taken))
    else begin
      $error("more than one push accepted in one cycle");
      fail_cnt++;
    end

  // Held beat must not move while the consumer stalls
  a_stall_hold: assert property (@(posedge clk) disable iff (!rst_n)
    (out_valid && !out_ready) |=> (out_valid && $stable(out_beat)))
    else begin
      $error("out_beat changed or dropped during a stall");
      fail_cnt++;
    end

  a_valid_after_push: assert property (@(posedge clk) disable iff (!rst_n)
    (|taken) |=> out_valid)
    else begin
      $error("out_valid low one cycle after an accepted push");
      fail_cnt++;
    end

  a_valid_cause: assert property (@(posedge clk) disable iff (!rst_n)
    $rose(out_valid) |-> $past(|taken))
    else begin
      $error("out_valid rose without an accepted push");
      fail_cnt++;
    end

endmodule

bind arb_top arb_asserts asrt_i (
  .clk         (clk),
  .rst_n       (rst_n),
  .push_valid  (push_valid),
  .push_ready  (push_ready),
  .stage_ready (stage_ready),
  .out_valid   (out_valid),
  .out_ready   (out_ready),
  .out_beat    (out_beat)
);

/* tb/arb_checker.sv */
// ----------------------------------------------------------
// Reference round-robin model, expected beat queue and
// per-cycle comparison against the arbiter top ports
// ----------------------------------------------------------

`timescale 1ns/1ps

module arb_checker (
  input  logic                clk,
  input  logic                rst_n,
  input  arb_pkg::req_vec_t   push_valid,
  input  arb_pkg::req_vec_t   push_ready,
  input  arb_pkg::push_data_t push_data,
  input  logic                out_valid,
  input  arb_pkg::pop_beat_t  out_beat,
  input  logic                out_ready,
  output int                  err_cnt,
  output int                  beat_cnt
);

  // Model state
  arb_pkg::req_id_t   ptr_m;
  logic               exp_valid;
  arb_pkg::pop_beat_t exp_q[$];
  logic               was_stalled;
  arb_pkg::pop_beat_t held_beat;

  initial begin
    err_cnt  = 0;
    beat_cnt = 0;
  end

  // First valid index at or after ptr, wrapping upward
  function automatic arb_pkg::req_id_t rr_pick(input arb_pkg::req_vec_t valid,
                                               input arb_pkg::req_id_t  ptr);
    int               idx;
    arb_pkg::req_id_t pick;
    pick = ptr;
    // Scan from farthest to nearest, nearer hits overwrite
    for (int k = arb_pkg::num_req - 1; k >= 0; k--) begin
      idx = (int'(ptr) + k) % arb_pkg::num_req;
      if (valid[idx]) begin
        pick = arb_pkg::req_id_t'(idx);
      end
    end
    return pick;
  endfunction

  task automatic report_mismatch(input string test, input logic [31:0] expected,
                                 input logic [31:0] actual);
    $display("ERR %s expected=%0h actual=%0h at %0t", test, expected, actual, $time);
    err_cnt++;
  endtask

  // ----------------------------------------------------------
  // Compare on every rising edge
  // ----------------------------------------------------------
  always @(posedge clk) begin
    arb_pkg::req_vec_t  exp_acc;
    arb_pkg::req_vec_t  act_acc;
    arb_pkg::req_vec_t  exp_ready;
    arb_pkg::pop_beat_t want;
    arb_pkg::pop_beat_t fresh;
    arb_pkg::req_id_t   win;
    logic               stage_free;
    if (!rst_n) begin
      ptr_m       = '0;
      exp_valid   = 1'b0;
      was_stalled = 1'b0;
      exp_q.delete();
    end else begin
      // Output stage takes a beat when empty or draining
      stage_free = !exp_valid || out_ready;
      if (out_valid !== exp_valid) begin
        report_mismatch("out_valid", exp_valid, out_valid);
      end
      if (was_stalled && out_beat !== held_beat) begin
        report_mismatch("stall_hold", held_beat, out_beat);
      end
      // Beat leaving toward the consumer
      if (exp_valid && out_ready) begin
        if (exp_q.size() == 0) begin
          $display("Output beat seen with no accepted push pending at %0t", $time);
          err_cnt++;
        end else begin
          want = exp_q.pop_front();
          if (out_beat !== want) begin
            report_mismatch("payload", want, out_beat);
          end
          beat_cnt++;
        end
      end
      // Expected winner of this cycle
      exp_acc = '0;
      if (stage_free && |push_valid) begin
        win          = rr_pick(push_valid, ptr_m);
        exp_acc[win] = 1'b1;
        fresh.data   = push_data[win];
        fresh.src    = win;
        exp_q.push_back(fresh);
        ptr_m = arb_pkg::req_id_t'((int'(win) + 1) % arb_pkg::num_req);
      end
      act_acc = push_valid & push_ready & {arb_pkg::num_req{stage_free}};
      if (act_acc !== exp_acc) begin
        report_mismatch("rr_order", exp_acc, act_acc);
      end
      // Ready high unless some other index wins
      exp_ready = (exp_acc == '0) ? '1 : exp_acc;
      if (push_ready !== exp_ready) begin
        report_mismatch("push_ready", exp_ready, push_ready);
      end
      was_stalled = exp_valid && !out_ready;
      held_beat   = out_beat;
      if (stage_free) begin
        exp_valid = |push_valid;
      end
    end
  end

endmodule

/* tb/arb_tb.sv */
// ----------------------------------------------------------
// Arbiter testbench with clock, reset, requester and consumer
// stimulus, watchdog and closing summary
// ----------------------------------------------------------

`timescale 1ns/1ps

module arb_tb;

  localparam int  clk_period   = 8;
  localparam int  reset_cycles = 5;
  localparam int  n_beats      = 40;
  localparam int  dense_cycles = 24;
  localparam int  stall_cycles = 20;
  localparam int  total_beats  = arb_pkg::num_req * n_beats;
  localparam real timeout_ns   = clk_period * (n_beats * arb_pkg::num_req * 4 + 200);

  // Starts low before any process runs, so no edge is seen at time zero
  logic                clk = 1'b0;
  logic                rst_n;
  arb_pkg::req_vec_t   push_valid;
  arb_pkg::req_vec_t   push_ready;
  arb_pkg::push_data_t push_data;
  logic                out_valid;
  arb_pkg::pop_beat_t  out_beat;
  logic                out_ready;

  // Stimulus state
  integer            seed;
  int                rst_cnt;
  int                cyc;
  int                sent [arb_pkg::num_req];
  int                gap [arb_pkg::num_req];
  arb_pkg::req_vec_t taken;
  int                err_cnt;
  int                beat_cnt;

  arb_top dut_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .push_valid (push_valid),
    .push_ready (push_ready),
    .push_data  (push_data),
    .out_valid  (out_valid),
    .out_beat   (out_beat),
    .out_ready  (out_ready)
  );

  arb_checker chk_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .push_valid (push_valid),
    .push_ready (push_ready),
    .push_data  (push_data),
    .out_valid  (out_valid),
    .out_beat   (out_beat),
    .out_ready  (out_ready),
    .err_cnt    (err_cnt),
    .beat_cnt   (beat_cnt)
  );

  always #(clk_period / 2) clk = ~clk;

  // Transfers of this edge, seen by the requesters at the next falling edge
  always @(posedge clk) begin
    taken = push_valid & push_ready & {arb_pkg::num_req{!out_valid || out_ready}};
  end

  // Each requester holds valid and data until taken, then waits a gap
  task automatic drive_requesters();
    for (int i = 0; i < arb_pkg::num_req; i++) begin
      if (taken[i]) begin
        push_valid[i] = 1'b0;
        sent[i]++;
        gap[i] = (cyc < dense_cycles + stall_cycles) ? 0 : ($random(seed) & 3);
      end
      if (!push_valid[i] && sent[i] < n_beats) begin
        if (gap[i] == 0) begin
          push_valid[i] = 1'b1;
          push_data[i]  = arb_pkg::data_t'($random(seed));
        end else begin
          gap[i]--;
        end
      end
    end
  endtask

  // Dense phase, then a long stall, then random back-pressure
  task automatic drive_consumer();
    if (cyc < dense_cycles) begin
      out_ready = 1'b1;
    end else if (cyc < dense_cycles + stall_cycles) begin
      out_ready = 1'b0;
    end else begin
      out_ready = (($random(seed) & 3) != 0);
    end
  endtask

  always @(negedge clk) begin
    if (!rst_n) begin
      rst_cnt++;
      if (rst_cnt == reset_cycles) begin
        rst_n = 1'b1;
      end
    end else begin
      drive_requesters();
      drive_consumer();
      cyc++;
    end
  end

  initial begin
    seed       = 76055;
    rst_n      = 1'b0;
    push_valid = '0;
    push_data  = '0;
    out_ready  = 1'b0;
    rst_cnt    = 0;
    cyc        = 0;
    taken      = '0;
    for (int i = 0; i < arb_pkg::num_req; i++) begin
      sent[i] = 0;
      gap[i]  = 0;
    end
    wait (beat_cnt == total_beats);
    repeat (4) @(posedge clk);
    $display("Summary: beats=%0d checker_errors=%0d assertion_failures=%0d",
             beat_cnt, err_cnt, dut_i.asrt_i.fail_cnt);
    if (err_cnt == 0 && dut_i.asrt_i.fail_cnt == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

  // Watchdog sized from the beat count
  initial begin
    #(timeout_ns);
    $display("Watchdog timeout with %0d of %0d beats delivered", beat_cnt, total_beats);
    $display("RESULT: FAIL");
    $finish;
  end

endmodule

/* all.f */
rtl/arb_pkg.sv
rtl/arb_rr_ctrl.sv
rtl/flow_arb_rr.sv
rtl/grant_mux.sv
rtl/pop_stage.sv
rtl/arb_top.sv
tb/arb_asserts.sv
tb/arb_checker.sv
tb/arb_tb.sv
